// File: source/lsu_params.svh
/* width, byte-lane and depth macros of the load/store unit */

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// data path
////////////////////////////////////////////////////////////////////////////

`define LSU_XLEN  32  // address and data width
`define LSU_BE_W  4   // one enable per byte lane
`define LSU_OFS_W 2   // byte offset inside a word

////////////////////////////////////////////////////////////////////////////
// bus side
////////////////////////////////////////////////////////////////////////////

`define LSU_DEPTH 2   // max transactions granted but not yet answered

`endif

// File: source/lsu_access_pkg.sv
/* access descriptor types: data size, load extension mode, byte offset */

`include "lsu_params.svh"

package lsu_access_pkg;

  // access size as encoded by the decoder
  typedef enum logic [1:0] {
    LSU_SIZE_WORD  = 2'b00,
    LSU_SIZE_HALF  = 2'b01,
    LSU_SIZE_BYTE  = 2'b10,
    LSU_SIZE_BYTE2 = 2'b11  // alias, also a byte access
  } lsu_size_e;

  // how the upper bits of a short load are filled
  typedef enum logic [1:0] {
    LSU_EXT_ZERO = 2'b00,  // lbu / lhu
    LSU_EXT_SIGN = 2'b01,  // lb / lh
    LSU_EXT_ONES = 2'b10   // all-ones fill
  } lsu_ext_e;

  // byte position inside a word, also the register offset of stores
  typedef logic [`LSU_OFS_W-1:0] lsu_ofs_t;

endpackage

// File: source/lsu_bus_pkg.sv
/* data bus types: word, byte enables, outstanding transaction count */

`include "lsu_params.svh"

package lsu_bus_pkg;

  // address or data word on the bus
  typedef logic [`LSU_XLEN-1:0] lsu_word_t;

  // byte enables, bit n covers bits 8n+7 .. 8n
  typedef logic [`LSU_BE_W-1:0] lsu_be_t;

  // granted requests still waiting for rvalid, 0 .. LSU_DEPTH
  typedef logic [$clog2(`LSU_DEPTH+1)-1:0] lsu_cnt_t;

endpackage

// File: source/lsu_request_gen.sv
/* address phase of the LSU with effective address, misalignment check,
   byte enables and store data rotation */

`timescale 1ns/1ps

`include "lsu_params.svh"

module lsu_request_gen
  import lsu_access_pkg::*;
  import lsu_bus_pkg::*;
(
  input  lsu_word_t operand_a_i,          // base register
  input  lsu_word_t operand_b_i,          // offset / immediate
  input  logic      addr_useincr_i,       // a + b when set, else a alone
  input  logic      data_req_ex_i,        // EX wants a bus access
  input  logic      data_misaligned_ex_i, // second pass of a split access
  input  lsu_size_e data_type_i,
  input  lsu_ofs_t  data_reg_offset_i,    // byte lane of the store data in rs2
  input  lsu_word_t data_wdata_ex_i,
  output lsu_word_t trans_addr_o,
  output lsu_word_t trans_wdata_o,
  output lsu_be_t   trans_be_o,
  output lsu_ofs_t  addr_ofs_o,           // low address bits for WB alignment
  output logic      data_misaligned_o     // first pass needs a second access
);

  lsu_word_t addr_int;   // effective address before second-pass alignment
  lsu_ofs_t  ofs;        // byte offset of the effective address
  lsu_ofs_t  wdata_ofs;  // lane distance for store data

  ////////////////////////////////////////////////////////////////////////////
  // address
  ////////////////////////////////////////////////////////////////////////////

  assign addr_int = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign ofs      = addr_int[`LSU_OFS_W-1:0];
  assign addr_ofs_o = ofs;

  // second pass starts at the next word boundary
  assign trans_addr_o = data_misaligned_ex_i ? {addr_int[`LSU_XLEN-1:`LSU_OFS_W], 2'b00}
                                             : addr_int;

  // words off alignment and halfwords crossing into the next word
  always_comb begin
    data_misaligned_o = 1'b0;
    if (data_req_ex_i && !data_misaligned_ex_i) begin
      case (data_type_i)
        LSU_SIZE_WORD: data_misaligned_o = (ofs != 2'b00);
        LSU_SIZE_HALF: data_misaligned_o = (ofs == 2'b11);
        default:       data_misaligned_o = 1'b0;  // bytes never split
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (data_type_i)
      LSU_SIZE_WORD: begin
        if (!data_misaligned_ex_i) begin
          trans_be_o = 4'b1111 << ofs;           // upper lanes from offset on
        end else begin
          trans_be_o = ~(4'b1111 << ofs);        // lanes left over from pass one
        end
      end
      LSU_SIZE_HALF: begin
        if (!data_misaligned_ex_i) begin
          trans_be_o = 4'b0011 << ofs;           // ofs 3 leaves only lane 3
        end else begin
          trans_be_o = 4'b0001;                  // upper byte of a split half
        end
      end
      default: trans_be_o = 4'b0001 << ofs;      // single byte lane
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // store data
  ////////////////////////////////////////////////////////////////////////////

  // move the register byte lane onto the addressed bus lane
  assign wdata_ofs = ofs - data_reg_offset_i;

  always_comb begin
    case (wdata_ofs)
      2'd0: trans_wdata_o = data_wdata_ex_i;
      2'd1: trans_wdata_o = {data_wdata_ex_i[23:0], data_wdata_ex_i[31:24]};
      2'd2: trans_wdata_o = {data_wdata_ex_i[15:0], data_wdata_ex_i[31:16]};
      default: trans_wdata_o = {data_wdata_ex_i[7:0], data_wdata_ex_i[31:8]};
    endcase
  end

endmodule

// File: source/lsu_outstanding_ctrl.sv
/* outstanding transaction counter, request gating and ready/busy levels */

`timescale 1ns/1ps

`include "lsu_params.svh"

module lsu_outstanding_ctrl
  import lsu_bus_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic data_req_ex_i,   // EX holds a load or store
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  output logic data_req_o,
  output logic lsu_ready_ex_o,  // EX may advance
  output logic lsu_ready_wb_o,  // WB may advance
  output logic busy_o,
  output logic ctrl_update_o    // EX hands its access to WB
);

  lsu_cnt_t cnt_q;     // granted but not yet answered
  lsu_cnt_t cnt_d;
  logic     accept;    // request and grant in the same cycle

  ////////////////////////////////////////////////////////////////////////////
  // request gating
  ////////////////////////////////////////////////////////////////////////////

  // a full counter simply blocks the request
  assign data_req_o = data_req_ex_i && (cnt_q < `LSU_DEPTH);
  assign accept     = data_req_o && data_gnt_i;

  assign busy_o = (cnt_q != '0) || data_req_o;

  // WB is free when empty or when its pending response arrives now
  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : data_rvalid_i;

  // EX and WB move in lock step once WB holds an access
  always_comb begin
    if (!data_req_ex_i) begin
      lsu_ready_ex_o = 1'b1;
    end else begin
      case (cnt_q)
        2'd0:    lsu_ready_ex_o = accept;
        2'd1:    lsu_ready_ex_o = accept && data_rvalid_i;
        default: lsu_ready_ex_o = data_rvalid_i;  // full until a slot frees
      endcase
    end
  end

  assign ctrl_update_o = lsu_ready_ex_o && data_req_ex_i;

  ////////////////////////////////////////////////////////////////////////////
  // counter
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case ({accept, data_rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;  // none or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // the count must stay in range over any run of grants and responses
  a_cnt_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= `LSU_DEPTH);

  // memory answers only what it was asked
  a_no_spurious_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> (cnt_q != '0));

endmodule

// File: source/lsu_load_align.sv
/* WB side of the LSU with registered access descriptor, load data alignment,
   extension and assembly of split loads */

`timescale 1ns/1ps

`include "lsu_params.svh"

module lsu_load_align
  import lsu_access_pkg::*;
  import lsu_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      ctrl_update_i,        // capture the EX descriptor
  input  logic      data_we_ex_i,
  input  logic      data_rvalid_i,
  input  logic      data_misaligned_ex_i, // second pass in EX
  input  logic      data_misaligned_i,    // first pass of a split in EX
  input  lsu_size_e data_type_i,
  input  lsu_ext_e  data_sign_ext_i,
  input  lsu_ofs_t  addr_ofs_i,
  input  lsu_word_t data_rdata_i,
  output lsu_word_t data_rdata_ex_o
);

  // descriptor of the access that owns the next response
  lsu_size_e type_q;
  lsu_ext_e  ext_q;
  lsu_ofs_t  ofs_q;
  logic      we_q;

  lsu_word_t rdata_q;     // first beat of a split or else the last result
  lsu_word_t word_raw;
  logic [15:0] half_raw;
  logic [7:0]  byte_raw;
  logic      fill_h;      // fill bit above a halfword
  logic      fill_b;      // fill bit above a byte
  lsu_word_t rdata_ext;   // finished result of this beat

  // fill bit from the extension mode and the value's top bit
  function automatic logic fill_bit(input lsu_ext_e mode, input logic msb);
    case (mode)
      LSU_EXT_ZERO: return 1'b0;
      LSU_EXT_ONES: return 1'b1;
      default:      return msb;  // sign
    endcase
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      type_q <= LSU_SIZE_WORD;
      ext_q  <= LSU_EXT_ZERO;
      ofs_q  <= '0;
      we_q   <= 1'b0;
    end else if (ctrl_update_i) begin  // granted and now waiting for rvalid
      type_q <= data_type_i;
      ext_q  <= data_sign_ext_i;
      ofs_q  <= addr_ofs_i;
      we_q   <= data_we_ex_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // lane select
  ////////////////////////////////////////////////////////////////////////////

  // a split word takes its high bytes from this beat and the rest from the first beat
  always_comb begin
    case (ofs_q)
      2'd0: word_raw = data_rdata_i;
      2'd1: word_raw = {data_rdata_i[7:0], rdata_q[31:8]};
      2'd2: word_raw = {data_rdata_i[15:0], rdata_q[31:16]};
      default: word_raw = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    case (ofs_q)
      2'd0: half_raw = data_rdata_i[15:0];
      2'd1: half_raw = data_rdata_i[23:8];
      2'd2: half_raw = data_rdata_i[31:16];
      default: half_raw = {data_rdata_i[7:0], rdata_q[31:24]};  // crosses words
    endcase
  end

  assign byte_raw = data_rdata_i[{ofs_q, 3'b000} +: 8];

  ////////////////////////////////////////////////////////////////////////////
  // extension
  ////////////////////////////////////////////////////////////////////////////

  assign fill_h = fill_bit(ext_q, half_raw[15]);
  assign fill_b = fill_bit(ext_q, byte_raw[7]);

  always_comb begin
    case (type_q)
      LSU_SIZE_WORD: rdata_ext = word_raw;
      LSU_SIZE_HALF: rdata_ext = {{(`LSU_XLEN-16){fill_h}}, half_raw};
      default:       rdata_ext = {{(`LSU_XLEN-8){fill_b}}, byte_raw};
    endcase
  end

  // raw beat kept while a split load is in flight
  always_ff @(posedge clk) begin
    if (data_rvalid_i && !we_q) begin
      if (data_misaligned_ex_i || data_misaligned_i) begin
        rdata_q <= data_rdata_i;
      end else begin
        rdata_q <= rdata_ext;
      end
    end
  end

  assign data_rdata_ex_o = (data_rvalid_i && !we_q) ? rdata_ext : rdata_q;

endmodule

// File: source/lsu_top.sv
/* top level of the data-side load/store unit, pipeline and data bus ports */

`timescale 1ns/1ps

module lsu_top
  import lsu_access_pkg::*;
  import lsu_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // pipeline, EX stage
  input  logic      data_req_ex_i,
  input  logic      data_we_ex_i,
  input  lsu_size_e data_type_ex_i,
  input  lsu_ext_e  data_sign_ext_ex_i,
  input  lsu_word_t data_wdata_ex_i,
  input  lsu_ofs_t  data_reg_offset_ex_i,
  input  lsu_word_t operand_a_ex_i,
  input  lsu_word_t operand_b_ex_i,
  input  logic      addr_useincr_ex_i,
  input  logic      data_misaligned_ex_i,
  output lsu_word_t data_rdata_ex_o,      // load result toward WB
  output logic      data_misaligned_o,    // request a second pass
  output logic      lsu_ready_ex_o,
  output logic      lsu_ready_wb_o,
  output logic      busy_o,

  // data bus
  output logic      data_req_o,
  input  logic      data_gnt_i,
  input  logic      data_rvalid_i,
  output lsu_word_t data_addr_o,
  output logic      data_we_o,
  output lsu_be_t   data_be_o,
  output lsu_word_t data_wdata_o,
  input  lsu_word_t data_rdata_i
);

  lsu_ofs_t addr_ofs;     // low address bits of the EX access
  logic     ctrl_update;  // EX descriptor moves to WB

  assign data_we_o = data_we_ex_i;  // held stable by EX until granted

  lsu_request_gen u_request_gen (
    .operand_a_i          (operand_a_ex_i),
    .operand_b_i          (operand_b_ex_i),
    .addr_useincr_i       (addr_useincr_ex_i),
    .data_req_ex_i        (data_req_ex_i),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_type_i          (data_type_ex_i),
    .data_reg_offset_i    (data_reg_offset_ex_i),
    .data_wdata_ex_i      (data_wdata_ex_i),
    .trans_addr_o         (data_addr_o),
    .trans_wdata_o        (data_wdata_o),
    .trans_be_o           (data_be_o),
    .addr_ofs_o           (addr_ofs),
    .data_misaligned_o    (data_misaligned_o)
  );

  lsu_outstanding_ctrl u_outstanding_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o),
    .ctrl_update_o  (ctrl_update)
  );

  lsu_load_align u_load_align (
    .clk                  (clk),
    .rst_n                (rst_n),
    .ctrl_update_i        (ctrl_update),
    .data_we_ex_i         (data_we_ex_i),
    .data_rvalid_i        (data_rvalid_i),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_misaligned_i    (data_misaligned_o),
    .data_type_i          (data_type_ex_i),
    .data_sign_ext_i      (data_sign_ext_ex_i),
    .addr_ofs_i           (addr_ofs),
    .data_rdata_i         (data_rdata_i),
    .data_rdata_ex_o      (data_rdata_ex_o)
  );

  // address phase comes from two modules and the pipeline, all must be defined
  a_addr_phase_known: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o |-> !$isunknown({data_addr_o, data_we_o, data_be_o}));

endmodule

// File: verif/lsu_checker.sv
/* LSU checker comparing bus phase, request, ready, busy and load results
   against the pattern file and printing one line per test */

`timescale 1ns/1ps

module lsu_checker
  import lsu_access_pkg::*;
  import lsu_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  int        test_idx_i,          // test now driven by the pipeline model
  input  logic      test_done_i,         // one cycle pulse after the last response
  input  logic      data_req_ex_i,
  input  lsu_word_t data_rdata_ex_o,
  input  logic      data_misaligned_o,
  input  logic      lsu_ready_ex_o,
  input  logic      lsu_ready_wb_o,
  input  logic      busy_o,
  input  logic      data_req_o,
  input  logic      data_gnt_i,
  input  logic      data_rvalid_i,
  input  lsu_word_t data_addr_o,
  input  logic      data_we_o,
  input  lsu_be_t   data_be_o,
  input  lsu_word_t data_wdata_o,
  output int        err_cnt_o,
  output int        fail_tests_o
);

  localparam int NUM_TESTS = 18;
  localparam int NF        = 15;  // fields per test line

  lsu_word_t pat [0:NUM_TESTS*NF-1];
  lsu_word_t p [0:NF-1];           // fields of the current test
  lsu_word_t base;                 // effective address of the first pass
  lsu_word_t exp_addr;
  logic      mis_exp;
  logic      exp_req;              // bus request level for this cycle
  logic      exp_acc;              // request meets grant
  logic      exp_ready_ex;
  int        beats;                // bus accesses this test needs
  int        acc_n;                // accepted requests in this test
  int        rsp_n;                // responses in this test
  int        owed;                 // accepted minus answered
  int        test_errs;
  int        last_test;
  logic      hold;                 // request waited for grant last cycle
  lsu_word_t hold_addr;
  lsu_word_t hold_wdata;
  lsu_be_t   hold_be;
  logic      hold_we;

  initial begin
    $readmemh("verif/lsu_patterns.txt", pat);
    err_cnt_o    = 0;
    fail_tests_o = 0;
    acc_n = 0;
    rsp_n = 0;
    owed  = 0;
    test_errs = 0;
    last_test = 0;
    hold = 1'b0;
  end

  // print a FAILED line when a value mismatches
  task automatic compare_value(input string name, input lsu_word_t got,
                               input lsu_word_t exp);
    if (got !== exp) begin
      $display("FAILED test %0d %s got %h expected %h", test_idx_i, name, got, exp);
      err_cnt_o++;
      test_errs++;
    end
  endtask

  // plain-words failure that has no signal value to show
  task automatic report_problem(input string what);
    $display("test %0d: %s", test_idx_i, what);
    err_cnt_o++;
    test_errs++;
  endtask

  always @(posedge clk) begin
    if (rst_n && test_idx_i < NUM_TESTS) begin
      if (test_idx_i != last_test) begin  // fresh beat counters for a new test
        acc_n = 0;
        rsp_n = 0;
        test_errs = 0;
        last_test = test_idx_i;
      end
      for (int i = 0; i < NF; i++) begin
        p[i] = pat[test_idx_i*NF + i];
      end
      base    = p[1][0] ? p[5] + p[6] : p[5];      // a+b or a alone
      mis_exp = (p[2][1:0] == 2'd0 && base[1:0] != 2'd0) ||
                (p[2][1:0] == 2'd1 && base[1:0] == 2'd3);
      beats   = mis_exp ? 2 : 1;

      // address phase must not move while waiting for the grant
      if (hold && data_req_o) begin
        compare_value("data_addr_o", data_addr_o, hold_addr);
        compare_value("data_be_o", lsu_word_t'(data_be_o), lsu_word_t'(hold_be));
        compare_value("data_wdata_o", data_wdata_o, hold_wdata);
        compare_value("data_we_o", lsu_word_t'(data_we_o), lsu_word_t'(hold_we));
      end

      // requests pass through until two responses are owed
      exp_req = data_req_ex_i && (owed < 2);
      exp_acc = exp_req && data_gnt_i;
      compare_value("data_req_o", lsu_word_t'(data_req_o), lsu_word_t'(exp_req));
      compare_value("busy_o", lsu_word_t'(busy_o),
                    lsu_word_t'((owed != 0) || exp_req));
      compare_value("lsu_ready_wb_o", lsu_word_t'(lsu_ready_wb_o),
                    lsu_word_t'((owed == 0) || data_rvalid_i));

      if (!data_req_ex_i) begin
        exp_ready_ex = 1'b1;
      end else if (owed == 0) begin
        exp_ready_ex = exp_acc;
      end else if (owed == 1) begin
        exp_ready_ex = exp_acc && data_rvalid_i;  // needs both a slot and a grant
      end else begin
        exp_ready_ex = data_rvalid_i;
      end
      compare_value("lsu_ready_ex_o", lsu_word_t'(lsu_ready_ex_o),
                    lsu_word_t'(exp_ready_ex));

      if (owed > 2) report_problem("more than two requests are waiting for responses");

      if (data_req_o && data_gnt_i) begin
        if (acc_n >= beats) begin
          report_problem("the bus saw more requests than the access needs");
        end else begin
          if (acc_n == 0) begin
            compare_value("data_misaligned_o", lsu_word_t'(data_misaligned_o),
                          lsu_word_t'(mis_exp));
            exp_addr = base;
          end else begin
            exp_addr = (base + 32'd4) & ~32'd3;     // second pass at the word boundary
          end
          compare_value("data_addr_o", data_addr_o, exp_addr);
          compare_value("data_we_o", lsu_word_t'(data_we_o), p[0]);
          compare_value("data_be_o", lsu_word_t'(data_be_o), p[10 + 2*acc_n]);
          if (p[0][0]) compare_value("data_wdata_o", data_wdata_o, p[11 + 2*acc_n]);
        end
        acc_n++;
      end

      hold       = data_req_o && !data_gnt_i;
      hold_addr  = data_addr_o;
      hold_be    = data_be_o;
      hold_wdata = data_wdata_o;
      hold_we    = data_we_o;

      if (data_rvalid_i) begin
        if (!p[0][0] && rsp_n == beats - 1) begin  // final beat of a load
          compare_value("data_rdata_ex_o", data_rdata_ex_o, p[14]);
        end
        rsp_n++;
      end

      owed = owed + ((data_req_o && data_gnt_i) ? 1 : 0) - (data_rvalid_i ? 1 : 0);

      if (test_done_i) begin
        if (acc_n != beats || rsp_n != beats) begin
          report_problem("the number of bus requests or responses is wrong");
        end
        if (test_errs == 0) begin
          $display("test %0d pass", test_idx_i);
        end else begin
          $display("test %0d fail, %0d errors", test_idx_i, test_errs);
          fail_tests_o++;
        end
      end
    end
  end

endmodule

// File: verif/tb_lsu.sv
/* LSU testbench with clock, reset, pipeline model, memory model and watchdog */

`timescale 1ns/1ps

module tb_lsu
  import lsu_access_pkg::*;
  import lsu_bus_pkg::*;
();

  localparam int NUM_TESTS = 18;
  localparam int NF        = 15;

  logic clk, rst_n;
  logic data_req_ex_i, data_we_ex_i, addr_useincr_ex_i, data_misaligned_ex_i;
  lsu_size_e data_type_ex_i;
  lsu_ext_e  data_sign_ext_ex_i;
  lsu_ofs_t  data_reg_offset_ex_i;
  lsu_word_t data_wdata_ex_i, operand_a_ex_i, operand_b_ex_i;
  lsu_word_t data_rdata_ex_o, data_addr_o, data_wdata_o, data_rdata_i;
  logic data_misaligned_o, lsu_ready_ex_o, lsu_ready_wb_o, busy_o;
  logic data_req_o, data_gnt_i, data_rvalid_i, data_we_o;
  lsu_be_t data_be_o;

  lsu_word_t pat [0:NUM_TESTS*NF-1];
  int        cur_test;
  logic      test_done;
  int        err_cnt, fail_tests;
  int        cyc;          // cycle count for response timing
  int        gnt_wait;     // cycles left before the next grant
  int        beat_n;       // accepted beats of the current test
  lsu_word_t rsp_data [$];
  int        rsp_due [$];

  lsu_top dut0 (.*);

  lsu_checker checker0 (
    .test_idx_i (cur_test),
    .test_done_i (test_done),
    .err_cnt_o (err_cnt),
    .fail_tests_o (fail_tests),
    .*
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cyc++;
    if (data_rvalid_i) begin  // response taken this cycle
      void'(rsp_data.pop_front());
      void'(rsp_due.pop_front());
    end
    if (data_req_o && data_gnt_i) begin
      rsp_data.push_back(pat[cur_test*NF + 8 + beat_n]);  // mem0 then mem1
      rsp_due.push_back(cyc + int'($urandom % 3));         // 1..3 cycles later
      beat_n++;
      gnt_wait = $urandom % 3;
    end else if (data_req_o && gnt_wait > 0) begin
      gnt_wait--;
    end
  end

  always @(negedge clk) begin
    data_gnt_i = rst_n && (gnt_wait == 0);
    if (rsp_data.size() > 0 && rsp_due[0] <= cyc) begin
      data_rvalid_i = 1'b1;
      data_rdata_i  = rsp_data[0];
    end else begin
      data_rvalid_i = 1'b0;
      data_rdata_i  = '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pipeline model
  ////////////////////////////////////////////////////////////////////////////

  // hold the request until EX may advance
  task automatic wait_ready();
    do @(posedge clk); while (!lsu_ready_ex_o);
  endtask

  task automatic run_test(input int t);
    lsu_word_t f [0:NF-1];
    logic      mis;
    for (int i = 0; i < NF; i++) f[i] = pat[t*NF + i];
    @(negedge clk);
    cur_test             = t;
    beat_n               = 0;
    data_we_ex_i         = f[0][0];
    addr_useincr_ex_i    = f[1][0];
    data_type_ex_i       = lsu_size_e'(f[2][1:0]);
    data_sign_ext_ex_i   = lsu_ext_e'(f[3][1:0]);
    data_reg_offset_ex_i = f[4][1:0];
    operand_a_ex_i       = f[5];
    operand_b_ex_i       = f[6];
    data_wdata_ex_i      = f[7];
    data_misaligned_ex_i = 1'b0;
    data_req_ex_i        = 1'b1;
    wait_ready();
    mis = data_misaligned_o;  // first pass asks for a second access
    if (mis) begin  // reissue at the next word
      @(negedge clk);
      operand_a_ex_i       = f[5] + 32'd4;
      data_misaligned_ex_i = 1'b1;
      wait_ready();
    end
    @(negedge clk);
    data_req_ex_i        = 1'b0;
    data_misaligned_ex_i = 1'b0;
    do @(posedge clk); while (busy_o);  // all responses back
    @(negedge clk) test_done = 1'b1;
    @(negedge clk) test_done = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h19f6));
    $readmemh("verif/lsu_patterns.txt", pat);
    rst_n = 1'b0;
    data_req_ex_i = 1'b0;
    data_we_ex_i = 1'b0;
    data_type_ex_i = LSU_SIZE_WORD;
    data_sign_ext_ex_i = LSU_EXT_ZERO;
    data_wdata_ex_i = '0;
    data_reg_offset_ex_i = '0;
    operand_a_ex_i = '0;
    operand_b_ex_i = '0;
    addr_useincr_ex_i = 1'b0;
    data_misaligned_ex_i = 1'b0;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i = '0;
    cur_test = 0;
    test_done = 1'b0;
    cyc = 0;
    gnt_wait = 0;
    beat_n = 0;
    repeat (8) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) run_test(t);
    @(posedge clk);
    $display("tests run %0d, tests failed %0d, errors %0d", NUM_TESTS, fail_tests, err_cnt);
    if (err_cnt == 0 && fail_tests == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // no test needs more than 40 cycles
  initial begin
    repeat (NUM_TESTS*40 + 16) @(posedge clk);
    $display("timeout: the tests did not finish in the allowed number of cycles");
    $display("Checks failed");
    $finish;
  end

endmodule

// File: verif/lsu_patterns.txt
// we useincr size ext regofs opa opb wdata mem0 mem1
// exp_be0 exp_wdata0 exp_be1 exp_wdata1 exp_rdata
1 0 0 0 0 00001000 00000000 44332211 00000000 00000000 f 44332211 0 00000000 00000000
1 1 1 0 0 00001000 00000002 44332211 00000000 00000000 c 22114433 0 00000000 00000000
1 0 2 0 0 00001003 00000000 44332211 00000000 00000000 8 11443322 0 00000000 00000000
1 0 3 0 2 00001001 00000000 44332211 00000000 00000000 2 11443322 0 00000000 00000000
1 1 1 0 1 00001004 00000001 44332211 00000000 00000000 6 44332211 0 00000000 00000000
1 0 0 0 0 00002001 00000000 44332211 00000000 00000000 e 33221144 1 33221144 00000000
1 1 1 0 0 00002000 00000003 44332211 00000000 00000000 8 11443322 1 11443322 00000000
0 0 0 0 0 00003000 00000000 00000000 f1e2d3c4 0a0b0c7d f 00000000 0 00000000 f1e2d3c4
0 0 2 1 0 00003001 00000000 00000000 f1e2d3c4 0a0b0c7d 2 00000000 0 00000000 ffffffd3
0 0 2 0 0 00003002 00000000 00000000 f1e2d3c4 0a0b0c7d 4 00000000 0 00000000 000000e2
0 0 1 1 0 00003000 00000000 00000000 f1e2d3c4 0a0b0c7d 3 00000000 0 00000000 ffffd3c4
0 1 1 2 0 00003000 00000002 00000000 f1e2d3c4 0a0b0c7d c 00000000 0 00000000 fffff1e2
0 0 1 0 0 00003001 00000000 00000000 f1e2d3c4 0a0b0c7d 6 00000000 0 00000000 0000e2d3
0 0 3 2 0 00003003 00000000 00000000 f1e2d3c4 0a0b0c7d 8 00000000 0 00000000 fffffff1
0 0 0 0 0 00003001 00000000 00000000 f1e2d3c4 0a0b0c7d e 00000000 1 00000000 7df1e2d3
0 1 0 0 0 00003000 00000003 00000000 f1e2d3c4 0a0b0c7d 8 00000000 7 00000000 0b0c7df1
0 0 1 1 0 00003003 00000000 00000000 f1e2d3c4 0a0b0c7d 8 00000000 1 00000000 00007df1
0 0 0 0 0 00003002 00000000 00000000 f1e2d3c4 0a0b0c7d c 00000000 3 00000000 0c7df1e2

// File: src.f
+incdir+source
source/lsu_access_pkg.sv
source/lsu_bus_pkg.sv
source/lsu_request_gen.sv
source/lsu_outstanding_ctrl.sv
source/lsu_load_align.sv
source/lsu_top.sv
verif/lsu_checker.sv
verif/tb_lsu.sv
